// ==== design/bram_geom_pkg.sv ====
`default_nettype none

// physical geometry of the banked memory
// every width and mapping constant downstream is derived from these values
package bram_geom_pkg;

  // host side word, as seen by the bram controller
  localparam int DATA_WIDTH_IN = 32;   // host word width, multiple of DATA_WIDTH_OUT

  // narrow bank side
  localparam int DATA_WIDTH_OUT = 16;  // one datum per bank entry, whole bytes
  localparam int BANKS = 4;            // power of two, not below the lanes per word
  localparam int DEPTH_PER_BANK = 256; // entries per bank, power of two

  // cycles from a read enable to valid read data
  // 1 matches a plain registered bram, 2 or 3 add output registers
  localparam int RD_LATENCY = 1;

endpackage

`default_nettype wire

// ==== design/bram_port_pkg.sv ====
`default_nettype none

// port widths and lane mapping constants
// all derived from the geometry so only bram_geom_pkg needs editing
package bram_port_pkg;

  import bram_geom_pkg::*;

  // lanes packed in one host word, stored lsb first
  localparam int LANES = DATA_WIDTH_IN / DATA_WIDTH_OUT;

  localparam int BANK_BITS = $clog2(BANKS);  // bank index width
  localparam int LANE_BITS = $clog2(LANES);  // lane index width

  // bank side port
  localparam int ADDR_WIDTH_OUT = $clog2(DEPTH_PER_BANK);
  localparam int STRB_WIDTH_OUT = DATA_WIDTH_OUT / 8;  // one strobe per byte

  // host side port
  // total storage is the same, just counted in wide words
  localparam int TOTAL_DEPTH = BANKS * DEPTH_PER_BANK / LANES;
  localparam int ADDR_WIDTH_IN = $clog2(TOTAL_DEPTH);
  localparam int STRB_WIDTH_IN = DATA_WIDTH_IN / 8;

  // note: global lane number is {host addr, lane}, which is also
  // {bank addr, bank index}, so
  //   LANE_BITS + ADDR_WIDTH_IN == BANK_BITS + ADDR_WIDTH_OUT

endpackage

`default_nettype wire

// ==== design/bank_bus_if.sv ====
`default_nettype none

// per-bank request and response vectors between the translator and the banks
// index [b] of every vector belongs to bank b
interface bank_bus_if
  import bram_geom_pkg::*, bram_port_pkg::*;
(
  input logic clk
);

  // requests, driven from one combinational block in the translator
  logic [BANKS-1:0]                     rden;
  logic [BANKS-1:0]                     wren;
  logic [BANKS-1:0][STRB_WIDTH_OUT-1:0] wrstrb;  // byte enables per bank
  logic [BANKS-1:0][ADDR_WIDTH_OUT-1:0] addr;
  logic [BANKS-1:0][DATA_WIDTH_OUT-1:0] din;

  // responses, each bank drives only its own slice so these are nets
  wire  [BANKS-1:0][DATA_WIDTH_OUT-1:0] dout;
  wire  [BANKS-1:0]                     dack;  // one cycle per served read

  modport translator (
    input  clk,
    output rden, wren, wrstrb, addr, din,
    input  dout, dack
  );

  modport bank (
    input  clk,
    input  rden, wren, wrstrb, addr, din,
    output dout, dack
  );

endinterface

`default_nettype wire

// ==== design/bank_translator.sv ====
`default_nettype none

// splits one wide host access into per-lane bank accesses
// lane l of word A lands in bank (A*LANES+l) % BANKS at address (A*LANES+l) / BANKS,
// so consecutive lanes walk across consecutive banks
module bank_translator
  import bram_geom_pkg::*, bram_port_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_i,

  // host port, bram controller style
  input  logic                     rden_i,
  input  logic                     wren_i,
  input  logic [STRB_WIDTH_IN-1:0] wrstrb_i,
  input  logic [ADDR_WIDTH_IN-1:0] addr_i,
  input  logic [DATA_WIDTH_IN-1:0] din_i,
  output logic [DATA_WIDTH_IN-1:0] dout_o,
  output logic                     dack_o,

  // bank side
  bank_bus_if.translator           bus
);

  // per-lane decode of the host address
  logic [LANE_BITS+ADDR_WIDTH_IN-1:0] lane_glb  [LANES];  // global lane number
  logic [BANK_BITS-1:0]               lane_bank [LANES];  // target bank
  logic [ADDR_WIDTH_OUT-1:0]          lane_addr [LANES];  // entry inside that bank

  // bank index each lane was read from, one stage per cycle of read latency
  logic [BANK_BITS-1:0]               sel_pipe [RD_LATENCY][LANES];

  // address decode
  // LANES and BANKS are powers of two, so multiply and divide are bit slices
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      lane_glb[l]  = {addr_i, LANE_BITS'(l)};              // A*LANES + l
      lane_bank[l] = lane_glb[l][BANK_BITS-1:0];           // modulo BANKS
      lane_addr[l] = lane_glb[l][BANK_BITS +: ADDR_WIDTH_OUT];  // divided by BANKS
    end
  end

  // request fan-out
  // lanes of one word always hit distinct banks since LANES <= BANKS,
  // banks not touched by this word see all zeros
  always_comb begin
    bus.rden   = '0;
    bus.wren   = '0;
    bus.wrstrb = '0;
    bus.addr   = '0;
    bus.din    = '0;
    for (int l = 0; l < LANES; l++) begin
      bus.rden[lane_bank[l]]   = rden_i;
      bus.wren[lane_bank[l]]   = wren_i;
      bus.wrstrb[lane_bank[l]] = wrstrb_i[l*STRB_WIDTH_OUT +: STRB_WIDTH_OUT];  // lane bytes
      bus.addr[lane_bank[l]]   = lane_addr[l];
      bus.din[lane_bank[l]]    = din_i[l*DATA_WIDTH_OUT +: DATA_WIDTH_OUT];
    end
  end

  // steering pipeline
  // shifts every cycle, matching the bank read pipelines stage for stage,
  // so back-to-back reads each get their own steering
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int s = 0; s < RD_LATENCY; s++) begin
        for (int l = 0; l < LANES; l++) begin
          sel_pipe[s][l] <= '0;
        end
      end
    end else begin
      for (int l = 0; l < LANES; l++) begin
        sel_pipe[0][l] <= lane_bank[l];  // captured even when idle, dack qualifies it
        for (int s = 1; s < RD_LATENCY; s++) begin
          sel_pipe[s][l] <= sel_pipe[s-1][l];
        end
      end
    end
  end

  // read reassembly
  // the last stage names the bank that served each lane right now
  always_comb begin
    dout_o = '0;
    dack_o = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      dout_o[l*DATA_WIDTH_OUT +: DATA_WIDTH_OUT] = bus.dout[sel_pipe[RD_LATENCY-1][l]];
      dack_o = dack_o | bus.dack[sel_pipe[RD_LATENCY-1][l]];  // any lane bank acks
    end
  end

endmodule

`default_nettype wire

// ==== design/bram_bank.sv ====
`default_nettype none

// one narrow bank, byte writable, read data after RD_LATENCY edges
// behaves like a single port block ram with optional output registers
module bram_bank
  import bram_geom_pkg::*, bram_port_pkg::*;
#(
  parameter int BANK_IDX = 0  // which slice of the bank bus this bank owns
) (
  input  logic      clk,
  input  logic      rst_i,
  bank_bus_if.bank  bus
);

  logic [DATA_WIDTH_OUT-1:0] mem [DEPTH_PER_BANK];  // storage, no reset

  logic [DATA_WIDTH_OUT-1:0] rd_pipe [RD_LATENCY];  // read data stages
  logic [RD_LATENCY-1:0]     ack_pipe;              // read valid, stage 0 at bit 0

  // write port
  // each strobe bit guards one byte of the datum
  always_ff @(posedge clk) begin
    if (bus.wren[BANK_IDX]) begin
      for (int b = 0; b < STRB_WIDTH_OUT; b++) begin
        if (bus.wrstrb[BANK_IDX][b]) begin
          mem[bus.addr[BANK_IDX]][b*8 +: 8] <= bus.din[BANK_IDX][b*8 +: 8];
        end
      end
    end
  end

  // read data pipeline
  // first stage is the ram output register, later stages just delay
  always_ff @(posedge clk) begin
    if (bus.rden[BANK_IDX]) begin
      rd_pipe[0] <= mem[bus.addr[BANK_IDX]];  // sees a write from the previous edge
    end
    for (int s = 1; s < RD_LATENCY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  // ack pipeline runs beside the data
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_pipe <= '0;
    end else begin
      ack_pipe[0] <= bus.rden[BANK_IDX];
      for (int s = 1; s < RD_LATENCY; s++) begin
        ack_pipe[s] <= ack_pipe[s-1];
      end
    end
  end

  // only this bank's slice of the response nets
  assign bus.dout[BANK_IDX] = rd_pipe[RD_LATENCY-1];
  assign bus.dack[BANK_IDX] = ack_pipe[RD_LATENCY-1];  // single cycle per read

endmodule

`default_nettype wire

// ==== design/mbank_mem_top.sv ====
`default_nettype none

// banked memory top
// one wide host port in front of BANKS narrow byte-writable banks
// host read latency equals the bank read latency
module mbank_mem_top
  import bram_geom_pkg::*, bram_port_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_i,

  input  logic                     rden_i,    // read strobe, never with wren_i
  input  logic                     wren_i,    // write strobe
  input  logic [STRB_WIDTH_IN-1:0] wrstrb_i,  // byte enables for writes
  input  logic [ADDR_WIDTH_IN-1:0] addr_i,    // word address
  input  logic [DATA_WIDTH_IN-1:0] din_i,
  output logic [DATA_WIDTH_IN-1:0] dout_o,    // valid while dack_o is high
  output logic                     dack_o     // one pulse per read
);

  // internal bank bus
  bank_bus_if bus_if (
    .clk (clk)
  );

  // host to bank translation and read reassembly
  bank_translator u_translator (
    .clk      (clk),
    .rst_i    (rst_i),
    .rden_i   (rden_i),
    .wren_i   (wren_i),
    .wrstrb_i (wrstrb_i),
    .addr_i   (addr_i),
    .din_i    (din_i),
    .dout_o   (dout_o),
    .dack_o   (dack_o),
    .bus      (bus_if.translator)
  );

  // narrow banks, each bound to its own slice of the bus
  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    bram_bank #(
      .BANK_IDX (b)
    ) u_bank (
      .clk   (clk),
      .rst_i (rst_i),
      .bus   (bus_if.bank)
    );
  end

endmodule

`default_nettype wire

// ==== sim/mbank_mem_props.sv ====
`default_nettype none

// protocol properties on the bank bus, bound into the translator
// widths come straight from the packages so other geometries still bind
module mbank_mem_props
  import bram_geom_pkg::*, bram_port_pkg::*;
(
  input wire logic             clk,
  input wire logic             rst_i,
  input wire logic             rden_i,       // host read strobe
  input wire logic             dack_o,       // host read acknowledge
  input wire logic [BANKS-1:0] bank_rden_i,  // per-bank read enables
  input wire logic [BANKS-1:0] bank_wren_i   // per-bank write enables
);

  // a bank cycle is either a read or a write, never both
  a_no_rd_wr: assert property (@(posedge clk) disable iff (rst_i)
    !((|bank_rden_i) && (|bank_wren_i)))
    else $error("bank bus carries read and write enables in the same cycle");

  // every lane of a host word reads from its own bank
  a_lane_fanout: assert property (@(posedge clk) disable iff (rst_i)
    rden_i |-> ($countones(bank_rden_i) == LANES))
    else $error("host read did not enable exactly one bank per lane");

  // the acknowledge follows the read strobe by the read latency, in both directions
  a_dack_timing: assert property (@(posedge clk) disable iff (rst_i)
    dack_o == $past(rden_i, RD_LATENCY))
    else $error("dack_o does not match the read strobe issued RD_LATENCY cycles earlier");

endmodule

bind bank_translator mbank_mem_props u_props (
  .clk         (clk),
  .rst_i       (rst_i),
  .rden_i      (rden_i),
  .dack_o      (dack_o),
  .bank_rden_i (bus.rden),
  .bank_wren_i (bus.wren)
);

`default_nettype wire

// ==== sim/mbank_mem_tb.sv ====
`default_nettype none

// self-checking testbench for the banked memory
// a flat word model predicts every read, a queue lines predictions up with dack_o
module mbank_mem_tb
  import bram_geom_pkg::*, bram_port_pkg::*;
();

  localparam int          CLK_HALF   = 4;
  localparam int          DRIVE_DLY  = 1;     // inputs change this long after posedge
  localparam int          MAX_CYCLES = 4000;  // roughly twice what the tests need
  localparam logic [31:0] SEED       = 32'h116;
  localparam int          N_STRB     = 128;   // partial strobe writes
  localparam int          N_RAW      = 64;    // write then read pairs
  localparam int          N_MIX      = 400;   // random operations

  logic                     clk;
  logic                     rst_i;
  logic                     rden_i;
  logic                     wren_i;
  logic [STRB_WIDTH_IN-1:0] wrstrb_i;
  logic [ADDR_WIDTH_IN-1:0] addr_i;
  logic [DATA_WIDTH_IN-1:0] din_i;
  logic [DATA_WIDTH_IN-1:0] dout_o;
  logic                     dack_o;

  logic [DATA_WIDTH_IN-1:0] model_mem [TOTAL_DEPTH];  // reference contents
  logic [DATA_WIDTH_IN-1:0] exp_word_q [$];            // outstanding reads
  int                       exp_due_q [$];             // cycle the dack is due
  string                    exp_name_q [$];

  logic [31:0] lfsr_state = SEED;
  int          cycle = 0;
  int          check_count = 0;
  int          err_count = 0;
  int          test_err_base = 0;
  int          read_count = 0;
  int          dack_count = 0;
  string       cur_test = "none";

  mbank_mem_top DUT (
    .clk      (clk),
    .rst_i    (rst_i),
    .rden_i   (rden_i),
    .wren_i   (wren_i),
    .wrstrb_i (wrstrb_i),
    .addr_i   (addr_i),
    .din_i    (din_i),
    .dout_o   (dout_o),
    .dack_o   (dack_o)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // cycle count doubles as the run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // 32-bit fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // byte merge as a byte-strobed write should behave
  function automatic logic [DATA_WIDTH_IN-1:0] merge_strobes(
    input logic [DATA_WIDTH_IN-1:0] old_word,
    input logic [DATA_WIDTH_IN-1:0] new_word,
    input logic [STRB_WIDTH_IN-1:0] strb
  );
    logic [DATA_WIDTH_IN-1:0] res;
    res = old_word;
    for (int i = 0; i < STRB_WIDTH_IN; i++) begin
      if (strb[i]) res[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return res;
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    #DRIVE_DLY;
    rden_i   = 1'b0;
    wren_i   = 1'b0;
    wrstrb_i = '0;
  endtask

  task automatic write_word(input logic [ADDR_WIDTH_IN-1:0] addr,
                            input logic [DATA_WIDTH_IN-1:0] data,
                            input logic [STRB_WIDTH_IN-1:0] strb);
    @(posedge clk);
    #DRIVE_DLY;
    rden_i   = 1'b0;
    wren_i   = 1'b1;
    wrstrb_i = strb;
    addr_i   = addr;
    din_i    = data;
    model_mem[addr] = merge_strobes(model_mem[addr], data, strb);  // lands at next edge
  endtask

  task automatic read_word(input logic [ADDR_WIDTH_IN-1:0] addr);
    @(posedge clk);
    #DRIVE_DLY;
    rden_i   = 1'b1;
    wren_i   = 1'b0;
    wrstrb_i = '0;
    addr_i   = addr;
    din_i    = '0;
    exp_word_q.push_back(model_mem[addr]);
    exp_due_q.push_back(cycle + RD_LATENCY);  // captured next edge, acked L edges on
    exp_name_q.push_back(cur_test);
    read_count++;
  endtask

  // wait until every outstanding read is acked or flagged missing
  task automatic drain_reads();
    while (exp_word_q.size() != 0) idle_cycle();
    idle_cycle();
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err_base = err_count;
  endtask

  task automatic end_test();
    drain_reads();
    if (err_count == test_err_base) $display("test %-18s ok", cur_test);
    else $display("test %-18s %0d errors", cur_test, err_count - test_err_base);
  endtask

  // response monitor, at negedge where dout_o and dack_o are settled
  always @(negedge clk) begin
    if (!rst_i) begin
      if (dack_o) begin
        dack_count++;
        check_count++;
        assert (exp_word_q.size() != 0) else begin
          $display("dack_o high in cycle %0d with no read outstanding", cycle);
          err_count++;
        end
        if (exp_word_q.size() != 0) begin
          check_count += 2;
          assert (exp_due_q[0] == cycle) else begin
            $display("dack_o for a %s read came in cycle %0d, due in cycle %0d",
                     exp_name_q[0], cycle, exp_due_q[0]);
            err_count++;
          end
          assert (dout_o === exp_word_q[0]) else begin
            $display("FAILED %s expected %h actual %h", exp_name_q[0], exp_word_q[0], dout_o);
            err_count++;
          end
          void'(exp_word_q.pop_front());
          void'(exp_due_q.pop_front());
          void'(exp_name_q.pop_front());
        end
      end else if (exp_word_q.size() != 0) begin
        check_count++;
        assert (exp_due_q[0] > cycle) else begin
          $display("dack_o missing for a %s read due in cycle %0d", exp_name_q[0], exp_due_q[0]);
          err_count++;
          void'(exp_word_q.pop_front());
          void'(exp_due_q.pop_front());
          void'(exp_name_q.pop_front());
        end
      end
    end
  end

  initial begin
    int addr_list [$];
    logic [ADDR_WIDTH_IN-1:0] a;
    logic [STRB_WIDTH_IN-1:0] s;
    logic [1:0]               op;
    int                       reads_before;
    int                       dacks_before;

    rst_i    = 1'b1;
    rden_i   = 1'b0;
    wren_i   = 1'b0;
    wrstrb_i = '0;
    addr_i   = '0;
    din_i    = '0;
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst_i = 1'b0;

    // 1. nothing issued, nothing acked
    begin_test("idle_after_reset");
    repeat (10) begin
      idle_cycle();
      @(negedge clk);
      check_count++;
      assert (dack_o == 1'b0) else begin
        $display("dack_o went high after reset with no read issued");
        err_count++;
      end
    end
    end_test();

    // 2. full fill, then back-to-back reads over every bank
    begin_test("fill_readback");
    for (int i = 0; i < TOTAL_DEPTH; i++) begin
      write_word(ADDR_WIDTH_IN'(i), rand_bits(DATA_WIDTH_IN), '1);
    end
    for (int i = 0; i < TOTAL_DEPTH; i++) read_word(ADDR_WIDTH_IN'(i));
    end_test();

    // 3. partial strobes over the filled words
    begin_test("byte_strobes");
    for (int i = 0; i < N_STRB; i++) begin
      a = ADDR_WIDTH_IN'(rand_bits(ADDR_WIDTH_IN));
      s = STRB_WIDTH_IN'(rand_bits(STRB_WIDTH_IN));
      if (s == '1) s = 4'b0101;  // keep at least one byte untouched
      write_word(a, rand_bits(DATA_WIDTH_IN), s);
      addr_list.push_back(int'(a));
    end
    foreach (addr_list[i]) read_word(ADDR_WIDTH_IN'(addr_list[i]));
    end_test();

    // 4. read right after a write to the same word
    begin_test("read_after_write");
    for (int i = 0; i < N_RAW; i++) begin
      a = ADDR_WIDTH_IN'(rand_bits(ADDR_WIDTH_IN));
      write_word(a, rand_bits(DATA_WIDTH_IN), STRB_WIDTH_IN'(rand_bits(STRB_WIDTH_IN)));
      read_word(a);
    end
    end_test();

    // 5. random idle, read and write mix
    begin_test("random_mix");
    reads_before = read_count;
    dacks_before = dack_count;
    for (int i = 0; i < N_MIX; i++) begin
      op = 2'(rand_bits(2));
      a  = ADDR_WIDTH_IN'(rand_bits(ADDR_WIDTH_IN));
      if (op == 2'd0) idle_cycle();
      else if (op == 2'd1) read_word(a);
      else write_word(a, rand_bits(DATA_WIDTH_IN), STRB_WIDTH_IN'(rand_bits(STRB_WIDTH_IN)));
    end
    drain_reads();
    check_count++;
    assert (dack_count - dacks_before == read_count - reads_before) else begin
      $display("FAILED random_mix expected %0d actual %0d", read_count - reads_before,
               dack_count - dacks_before);
      err_count++;
    end
    end_test();

    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/bram_geom_pkg.sv
design/bram_port_pkg.sv
design/bank_bus_if.sv
design/bank_translator.sv
design/bram_bank.sv
design/mbank_mem_top.sv
sim/mbank_mem_props.sv
sim/mbank_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the banked memory testbench with verilator and run it
# the pass line in sim.log decides the exit status

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module mbank_mem_tb -f vlog.f -o mbank_sim \
  && ./obj_dir/mbank_sim > sim.log 2>&1 \
  || echo "build or simulation ended early"

grep -q "^>>> PASS$" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }
